// File: flist.f
src/mips_pkg.sv
src/fetch_pc.sv
src/reg_file.sv
src/operand_forward.sv
src/decode_unit.sv
src/execute_alu.sv
src/mem_access.sv
src/mips_core.sv
verif/tb_clock.sv
verif/mips_core_asserts.sv
verif/tb_mips_core.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert --top-module tb_mips_core -f flist.f -o sim_tb \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || { echo "Simulation aborted, see sim.log"; exit 1; }
grep -q "Something failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// File: verif/tb_mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;

    localparam int          MEM_WORDS = 256;
    localparam int          TIMEOUT_CYCLES = 2000;
    localparam int          RES_BASE = 'h100;
    localparam int          DATA_ADDR = 'h200;
    localparam int          BYTE_ADDR = 'h280;
    localparam logic [15:0] MARK_ADDR = 16'h03fc;

    logic                clk;
    logic                rst_n;
    logic                init_req;
    logic [7:0]          dmem_idx;
    mips_pkg::word_t     imem_addr;
    mips_pkg::word_t     imem_rdata;
    mips_pkg::dbus_req_t dbus_req;
    mips_pkg::word_t     dbus_rdata;
    mips_pkg::word_t     imem [MEM_WORDS];
    mips_pkg::word_t     dmem [MEM_WORDS];
    mips_pkg::word_t     dmem_init [MEM_WORDS];
    mips_pkg::word_t     prog [$];
    mips_pkg::word_t     exp_q [$];
    int                  errors;
    int                  checks;

    tb_clock i_tb_clock (
        .clk_o(clk)
    );

    mips_core #(
        .RESET_PC(32'h0)
    ) i_mips_core (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_addr_o (imem_addr),
        .imem_rdata_i(imem_rdata),
        .dbus_req_o  (dbus_req),
        .dbus_rdata_i(dbus_rdata)
    );

    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_idx = dbus_req.addr[9:2];
    assign dbus_rdata = dbus_req.read ? dmem[dmem_idx] : 32'h0; // Data only under the read strobe

    function automatic mips_pkg::word_t merge_bytes(
        input mips_pkg::word_t old_word,
        input mips_pkg::word_t new_word,
        input logic [3:0]      be
    );
        mips_pkg::word_t merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    always @(posedge clk) begin
        if (init_req) begin
            dmem <= dmem_init;
        end else if (dbus_req.write) begin
            dmem[dmem_idx] <= merge_bytes(dmem[dmem_idx], dbus_req.wdata, dbus_req.be);
        end
    end

    function automatic mips_pkg::word_t fill_pattern(input int unsigned idx);
        return {8'hc3, idx[7:0] ^ 8'h5a, ~idx[7:0], idx[7:0]};
    endfunction

    function automatic mips_pkg::word_t r_type(
        input mips_pkg::funct_e fn,
        input logic [4:0]       rs,
        input logic [4:0]       rt,
        input logic [4:0]       rd,
        input logic [4:0]       shamt
    );
        return {6'h00, rs, rt, rd, shamt, fn};
    endfunction

    function automatic mips_pkg::word_t i_type(
        input mips_pkg::opcode_e op,
        input logic [4:0]        rs,
        input logic [4:0]        rt,
        input logic [15:0]       imm
    );
        return {op, rs, rt, imm};
    endfunction

    function automatic mips_pkg::word_t j_type(
        input mips_pkg::opcode_e op,
        input logic [25:0]       target
    );
        return {op, target};
    endfunction

    function automatic logic [15:0] slot_addr(input int slot);
        return 16'(RES_BASE + 4 * slot);
    endfunction

    task automatic check_equal(
        input mips_pkg::word_t actual,
        input mips_pkg::word_t expected,
        input string           what
    );
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t ns: %s: got %08h, expected %08h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic emit(input mips_pkg::word_t instr);
        prog.push_back(instr);
    endtask

    task automatic load_const(input logic [4:0] rd, input mips_pkg::word_t value);
        emit(i_type(mips_pkg::OP_LUI, 5'd0, rd, value[31:16]));
        emit(i_type(mips_pkg::OP_ORI, rd, rd, value[15:0]));
    endtask

    task automatic store_result(input logic [4:0] rt, input mips_pkg::word_t expected);
        emit(i_type(mips_pkg::OP_SW, 5'd0, rt, slot_addr(exp_q.size())));
        exp_q.push_back(expected);
    endtask

    // Stores r9 to the next slot; a skipped store leaves the fill pattern
    task automatic flag_store(input logic present);
        emit(i_type(mips_pkg::OP_SW, 5'd0, 5'd9, slot_addr(exp_q.size())));
        exp_q.push_back(present ? 32'h0000_0077 : fill_pattern(RES_BASE / 4 + exp_q.size()));
    endtask

    task automatic new_program();
        prog.delete();
        exp_q.delete();
        for (int i = 0; i < MEM_WORDS; i++) begin
            dmem_init[i] = fill_pattern(i);
        end
    endtask

    task automatic run_program(input string name);
        int   cycles;
        logic seen;
        emit(i_type(mips_pkg::OP_SW, 5'd0, 5'd0, MARK_ADDR));
        emit(j_type(mips_pkg::OP_J, 26'(prog.size()))); // Spin here once the marker is out
        emit(32'h0);
        @(negedge clk);
        rst_n = 1'b0;
        init_req = 1'b1;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : 32'h0;
        end
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        init_req = 1'b0;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            seen = dbus_req.write && (dbus_req.addr == {16'h0, MARK_ADDR});
        end
        if (!seen) begin
            errors++;
            $display("Timeout in %s: the final store did not appear within %0d cycles",
                     name, TIMEOUT_CYCLES);
        end else begin
            @(negedge clk);
            for (int i = 0; i < exp_q.size(); i++) begin
                check_equal(dmem[RES_BASE / 4 + i], exp_q[i], $sformatf("%s slot %0d", name, i));
            end
        end
    endtask

    task automatic reg_op(input mips_pkg::funct_e fn, input mips_pkg::word_t expected);
        emit(r_type(fn, 5'd1, 5'd2, 5'd3, 5'd0));
        store_result(5'd3, expected);
    endtask

    task automatic imm_op(
        input mips_pkg::opcode_e op,
        input logic [15:0]       imm,
        input mips_pkg::word_t   expected
    );
        emit(i_type(op, 5'd1, 5'd3, imm));
        store_result(5'd3, expected);
    endtask

    task automatic alu_results();
        mips_pkg::word_t a;
        mips_pkg::word_t b;
        mips_pkg::word_t simm;
        logic [15:0]     imm;
        logic [4:0]      sh;
        for (int round = 0; round < 3; round++) begin
            a = $urandom();
            b = $urandom();
            imm = 16'($urandom());
            sh = 5'($urandom());
            simm = {{16{imm[15]}}, imm};
            new_program();
            load_const(5'd1, a);
            load_const(5'd2, b);
            reg_op(mips_pkg::FN_ADDU, a + b);
            reg_op(mips_pkg::FN_SUBU, a - b);
            reg_op(mips_pkg::FN_AND, a & b);
            reg_op(mips_pkg::FN_OR, a | b);
            reg_op(mips_pkg::FN_XOR, a ^ b);
            reg_op(mips_pkg::FN_SLT, {31'b0, $signed(a) < $signed(b)});
            reg_op(mips_pkg::FN_SLTU, {31'b0, a < b});
            emit(r_type(mips_pkg::FN_SLL, 5'd0, 5'd2, 5'd3, sh));
            store_result(5'd3, b << sh);
            emit(r_type(mips_pkg::FN_SRL, 5'd0, 5'd2, 5'd3, sh));
            store_result(5'd3, b >> sh);
            imm_op(mips_pkg::OP_ADDIU, imm, a + simm);
            imm_op(mips_pkg::OP_ANDI, imm, a & {16'h0, imm});
            imm_op(mips_pkg::OP_ORI, imm, a | {16'h0, imm});
            imm_op(mips_pkg::OP_SLTI, imm, {31'b0, $signed(a) < $signed(simm)});
            imm_op(mips_pkg::OP_LUI, imm, {imm, 16'h0});
            run_program($sformatf("alu round %0d", round));
        end
    endtask

    task automatic dependency_chain();
        mips_pkg::word_t v;
        mips_pkg::word_t s2;
        mips_pkg::word_t s3;
        mips_pkg::word_t s4;
        mips_pkg::word_t s5;
        mips_pkg::word_t s6;
        v = $urandom();
        s2 = v + v;
        s3 = s2 + v;
        s4 = s3 + s2;
        s5 = s4 + s3;
        s6 = s5 - s2;
        new_program();
        load_const(5'd1, v);
        emit(r_type(mips_pkg::FN_ADDU, 5'd1, 5'd1, 5'd2, 5'd0));
        emit(r_type(mips_pkg::FN_ADDU, 5'd2, 5'd1, 5'd3, 5'd0));
        emit(r_type(mips_pkg::FN_ADDU, 5'd3, 5'd2, 5'd4, 5'd0));
        emit(r_type(mips_pkg::FN_ADDU, 5'd4, 5'd3, 5'd5, 5'd0));
        emit(r_type(mips_pkg::FN_SUBU, 5'd5, 5'd2, 5'd6, 5'd0));
        store_result(5'd2, s2);
        store_result(5'd3, s3);
        store_result(5'd4, s4);
        store_result(5'd5, s5);
        store_result(5'd6, s6);
        run_program("dependency chain");
    endtask

    task automatic load_use();
        mips_pkg::word_t v1;
        mips_pkg::word_t v2;
        logic [15:0]     imm;
        v1 = $urandom();
        v2 = $urandom();
        imm = 16'($urandom());
        new_program();
        dmem_init[DATA_ADDR / 4] = v1;
        dmem_init[DATA_ADDR / 4 + 1] = v2;
        dmem_init[DATA_ADDR / 4 + 2] = DATA_ADDR + 4; // Pointer to v2
        emit(i_type(mips_pkg::OP_LW, 5'd0, 5'd1, 16'(DATA_ADDR)));
        emit(r_type(mips_pkg::FN_ADDU, 5'd1, 5'd1, 5'd2, 5'd0));
        store_result(5'd2, v1 + v1);
        emit(i_type(mips_pkg::OP_LW, 5'd0, 5'd3, 16'(DATA_ADDR + 4)));
        store_result(5'd3, v2);
        emit(i_type(mips_pkg::OP_LW, 5'd0, 5'd4, 16'(DATA_ADDR)));
        emit(i_type(mips_pkg::OP_ADDIU, 5'd4, 5'd5, imm));
        store_result(5'd5, v1 + {{16{imm[15]}}, imm});
        emit(i_type(mips_pkg::OP_LW, 5'd0, 5'd6, 16'(DATA_ADDR + 8)));
        emit(i_type(mips_pkg::OP_LW, 5'd6, 5'd7, 16'h0000)); // Base register is the loaded pointer
        store_result(5'd7, v2);
        run_program("load use");
    endtask

    task automatic byte_access();
        mips_pkg::word_t w;
        mips_pkg::word_t w2;
        mips_pkg::word_t merged;
        logic [7:0]      lane;
        w = $urandom();
        w2 = ($urandom() | 32'h8000_8000) & 32'hff7f_ff7f; // Lanes 1 and 3 negative
        new_program();
        load_const(5'd1, w);
        for (int k = 0; k < 4; k++) begin
            merged = fill_pattern(RES_BASE / 4 + exp_q.size());
            merged[8*k +: 8] = w[7:0];
            emit(i_type(mips_pkg::OP_SB, 5'd0, 5'd1, slot_addr(exp_q.size()) + 16'(k)));
            exp_q.push_back(merged);
        end
        load_const(5'd2, w2);
        emit(i_type(mips_pkg::OP_SW, 5'd0, 5'd2, 16'(BYTE_ADDR)));
        for (int k = 0; k < 4; k++) begin
            lane = w2[8*k +: 8];
            emit(i_type(mips_pkg::OP_LB, 5'd0, 5'd3, 16'(BYTE_ADDR + k)));
            store_result(5'd3, {{24{lane[7]}}, lane});
            emit(i_type(mips_pkg::OP_LBU, 5'd0, 5'd4, 16'(BYTE_ADDR + k)));
            store_result(5'd4, {24'h0, lane});
        end
        run_program("byte access");
    endtask

    task automatic branch_jump();
        new_program();
        emit(i_type(mips_pkg::OP_ADDIU, 5'd0, 5'd1, 16'd5));
        emit(i_type(mips_pkg::OP_ADDIU, 5'd0, 5'd2, 16'd5));
        emit(i_type(mips_pkg::OP_ADDIU, 5'd0, 5'd3, 16'd7));
        emit(i_type(mips_pkg::OP_ADDIU, 5'd0, 5'd9, 16'h0077));
        emit(i_type(mips_pkg::OP_BEQ, 5'd1, 5'd2, 16'd2)); // Taken
        flag_store(1'b1);
        flag_store(1'b0);
        flag_store(1'b1);
        emit(i_type(mips_pkg::OP_BEQ, 5'd1, 5'd3, 16'd2));
        flag_store(1'b1);
        flag_store(1'b1);
        flag_store(1'b1);
        emit(i_type(mips_pkg::OP_BNE, 5'd1, 5'd3, 16'd2)); // Taken
        flag_store(1'b1);
        flag_store(1'b0);
        flag_store(1'b1);
        emit(i_type(mips_pkg::OP_BNE, 5'd1, 5'd2, 16'd2));
        flag_store(1'b1);
        flag_store(1'b1);
        flag_store(1'b1);
        emit(j_type(mips_pkg::OP_J, 26'(prog.size() + 3)));
        flag_store(1'b1);
        flag_store(1'b0);
        emit(i_type(mips_pkg::OP_ADDIU, 5'd0, 5'd5, 16'((prog.size() + 4) * 4)));
        emit(r_type(mips_pkg::FN_JR, 5'd5, 5'd0, 5'd0, 5'd0));
        flag_store(1'b1);
        flag_store(1'b0);
        flag_store(1'b1);
        run_program("branches and jumps");
    endtask

    task automatic zero_register();
        new_program();
        dmem_init[DATA_ADDR / 4] = 32'hdead_beef;
        emit(i_type(mips_pkg::OP_ADDIU, 5'd0, 5'd0, 16'h1234));
        store_result(5'd0, 32'h0);
        emit(i_type(mips_pkg::OP_ORI, 5'd0, 5'd0, 16'hffff));
        emit(32'h0);
        emit(32'h0);
        emit(32'h0);
        store_result(5'd0, 32'h0);
        emit(i_type(mips_pkg::OP_LW, 5'd0, 5'd0, 16'(DATA_ADDR)));
        store_result(5'd0, 32'h0);
        run_program("register zero");
    endtask

    initial begin
        errors = 0;
        checks = 0;
        rst_n = 1'b0;
        init_req = 1'b1;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = 32'h0;
            dmem_init[i] = fill_pattern(i);
        end
        void'($urandom(32'h1897));
        alu_results();
        dependency_chain();
        load_use();
        byte_access();
        branch_jump();
        zero_register();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/mips_core_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core_asserts (
    input wire                      clk,
    input wire                      rst_n,
    input wire mips_pkg::word_t     pc_i,
    input wire mips_pkg::dbus_req_t dbus_req_i
);

    strobe_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(dbus_req_i.read && dbus_req_i.write))
        else $error("Data bus read and write strobes are high together");

    idle_byte_enables: assert property (@(posedge clk) disable iff (!rst_n)
        !(dbus_req_i.read || dbus_req_i.write) |-> (dbus_req_i.be == 4'b0000))
        else $error("Data bus byte enables are set while the bus is idle");

    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc_i[1:0] == 2'b00)
        else $error("Fetch address is not word aligned");

    // Pipeline registers come out of reset holding bubbles
    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (!dbus_req_i.read && !dbus_req_i.write))
        else $error("Data bus strobe is high in the first cycle after reset");

endmodule

bind mips_core mips_core_asserts i_mips_core_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .pc_i      (imem_addr_o),
    .dbus_req_i(dbus_req_o)
);

`default_nettype wire

// File: verif/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD_NS = 2
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD_NS clk_o = ~clk_o; // 4 ns period
        end
    end

endmodule

`default_nettype wire

// File: src/mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core #(
    parameter mips_pkg::word_t RESET_PC = '0
) (
    input  wire                  clk,
    input  wire                  rst_n,
    output mips_pkg::word_t      imem_addr_o,
    input  wire mips_pkg::word_t imem_rdata_i,
    output mips_pkg::dbus_req_t  dbus_req_o,
    input  wire mips_pkg::word_t dbus_rdata_i
);

    mips_pkg::word_t     pc;
    mips_pkg::word_t     if_id_instr;
    mips_pkg::word_t     if_id_pc;
    mips_pkg::reg_addr_t rs_addr;
    mips_pkg::reg_addr_t rt_addr;
    mips_pkg::word_t     rs_file;
    mips_pkg::word_t     rt_file;
    mips_pkg::word_t     rs_val;
    mips_pkg::word_t     rt_val;
    logic                stall;
    logic                branch_taken;
    mips_pkg::word_t     branch_target;
    mips_pkg::id_ex_t    id_ctrl;
    mips_pkg::id_ex_t    id_ex_q;
    mips_pkg::ex_mm_t    ex_result;
    mips_pkg::ex_mm_t    ex_mm_q;
    mips_pkg::mm_wb_t    mm_result;
    mips_pkg::mm_wb_t    mm_wb_q;

    fetch_pc #(
        .RESET_PC(RESET_PC)
    ) i_fetch_pc (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall_i        (stall),
        .branch_taken_i (branch_taken),
        .branch_target_i(branch_target),
        .pc_o           (pc)
    );

    assign imem_addr_o = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_id_instr <= '0; // All-zero word is SLL r0, r0, 0
            if_id_pc <= '0;
        end else if (!stall) begin
            if_id_instr <= imem_rdata_i;
            if_id_pc <= pc;
        end
    end

    decode_unit i_decode_unit (
        .instr_i        (if_id_instr),
        .pc_i           (if_id_pc),
        .rs_val_i       (rs_val),
        .rt_val_i       (rt_val),
        .ctrl_o         (id_ctrl),
        .branch_taken_o (branch_taken),
        .branch_target_o(branch_target),
        .rs_addr_o      (rs_addr),
        .rt_addr_o      (rt_addr)
    );

    reg_file i_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_i     (mm_wb_q),
        .rs_addr_i(rs_addr),
        .rt_addr_i(rt_addr),
        .rs_data_o(rs_file),
        .rt_data_o(rt_file)
    );

    operand_forward i_operand_forward (
        .rs_addr_i(rs_addr),
        .rt_addr_i(rt_addr),
        .rs_file_i(rs_file),
        .rt_file_i(rt_file),
        .ex_i     (ex_result),
        .mm_i     (ex_mm_q),
        .mm_data_i(mm_result.data),
        .rs_o     (rs_val),
        .rt_o     (rt_val),
        .stall_o  (stall)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex_q <= '0;
        end else if (stall) begin
            id_ex_q <= '0; // Bubble while the load reaches memory
        end else begin
            id_ex_q <= id_ctrl;
        end
    end

    execute_alu i_execute_alu (
        .ctrl_i  (id_ex_q),
        .result_o(ex_result)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mm_q <= '0;
        end else begin
            ex_mm_q <= ex_result;
        end
    end

    mem_access i_mem_access (
        .mm_i        (ex_mm_q),
        .dbus_rdata_i(dbus_rdata_i),
        .dbus_req_o  (dbus_req_o),
        .wb_o        (mm_result)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mm_wb_q <= '0;
        end else begin
            mm_wb_q <= mm_result;
        end
    end

endmodule

`default_nettype wire

// File: src/mem_access.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access (
    input  wire mips_pkg::ex_mm_t mm_i,
    input  wire mips_pkg::word_t  dbus_rdata_i,
    output mips_pkg::dbus_req_t   dbus_req_o,
    output mips_pkg::mm_wb_t      wb_o
);

    logic            is_load;
    logic            is_store;
    logic            is_byte;
    logic [1:0]      lane;
    logic [7:0]      load_byte;
    mips_pkg::word_t load_val;

    assign is_load = (mm_i.mem_op == mips_pkg::MEM_LOAD);
    assign is_store = (mm_i.mem_op == mips_pkg::MEM_STORE);
    assign is_byte = (mm_i.mem_size == mips_pkg::SIZE_BYTE);
    assign lane = mm_i.result[1:0];
    assign load_byte = dbus_rdata_i[{lane, 3'b000} +: 8];

    always_comb begin
        dbus_req_o = '0;
        dbus_req_o.addr = mm_i.result;
        dbus_req_o.read = is_load;
        dbus_req_o.write = is_store;
        dbus_req_o.wdata = is_byte ? {4{mm_i.store_data[7:0]}} : mm_i.store_data;
        if (is_load || is_store) begin
            dbus_req_o.be = is_byte ? (4'b0001 << lane) : 4'b1111; // Lane 0 is the low byte
        end
    end

    always_comb begin
        if (!is_byte) begin
            load_val = dbus_rdata_i;
        end else if (mm_i.load_unsigned) begin
            load_val = {24'b0, load_byte};
        end else begin
            load_val = {{24{load_byte[7]}}, load_byte};
        end
    end

    assign wb_o = '{
        data: is_load ? load_val : mm_i.result,
        rd:   mm_i.rd,
        we:   mm_i.reg_we
    };

endmodule

`default_nettype wire

// File: src/execute_alu.sv
`timescale 1ns/1ps
`default_nettype none

module execute_alu (
    input  wire mips_pkg::id_ex_t ctrl_i,
    output mips_pkg::ex_mm_t      result_o
);

    logic            zero_ext;
    logic            is_load;
    mips_pkg::word_t ext_imm;
    mips_pkg::word_t op_b;
    mips_pkg::word_t alu_out;

    assign is_load = (ctrl_i.mem_op == mips_pkg::MEM_LOAD);

    // Address offsets are always sign-extended
    assign zero_ext = ctrl_i.imm_unsigned && (ctrl_i.mem_op == mips_pkg::MEM_NONE);
    assign ext_imm = zero_ext ? {16'b0, ctrl_i.imm} : {{16{ctrl_i.imm[15]}}, ctrl_i.imm};
    assign op_b = ctrl_i.imm_sel ? ext_imm : ctrl_i.b;

    always_comb begin
        case (ctrl_i.alu_op)
            mips_pkg::ALU_ADD:  alu_out = ctrl_i.a + op_b;
            mips_pkg::ALU_SUB:  alu_out = ctrl_i.a - op_b;
            mips_pkg::ALU_AND:  alu_out = ctrl_i.a & op_b;
            mips_pkg::ALU_OR:   alu_out = ctrl_i.a | op_b;
            mips_pkg::ALU_XOR:  alu_out = ctrl_i.a ^ op_b;
            mips_pkg::ALU_SLT:  alu_out = {31'b0, $signed(ctrl_i.a) < $signed(op_b)};
            mips_pkg::ALU_SLTU: alu_out = {31'b0, ctrl_i.a < op_b};
            mips_pkg::ALU_SLL:  alu_out = ctrl_i.a << op_b[4:0];
            mips_pkg::ALU_SRL:  alu_out = ctrl_i.a >> op_b[4:0];
            mips_pkg::ALU_LUI:  alu_out = {op_b[15:0], 16'b0};
            default:            alu_out = ctrl_i.a + op_b;
        endcase
    end

    assign result_o = '{
        result:        alu_out,
        store_data:    ctrl_i.b,
        mem_op:        ctrl_i.mem_op,
        mem_size:      ctrl_i.mem_size,
        load_unsigned: ctrl_i.imm_unsigned && is_load,
        rd:            ctrl_i.rd,
        reg_we:        ctrl_i.reg_we
    };

endmodule

`default_nettype wire

// File: src/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
    input  wire mips_pkg::word_t instr_i,
    input  wire mips_pkg::word_t pc_i,
    input  wire mips_pkg::word_t rs_val_i,
    input  wire mips_pkg::word_t rt_val_i,
    output mips_pkg::id_ex_t     ctrl_o,
    output logic                 branch_taken_o,
    output mips_pkg::word_t      branch_target_o,
    output mips_pkg::reg_addr_t  rs_addr_o,
    output mips_pkg::reg_addr_t  rt_addr_o
);

    mips_pkg::opcode_e opcode;
    mips_pkg::funct_e  funct;
    mips_pkg::word_t   slot_pc;
    mips_pkg::word_t   br_target;
    mips_pkg::word_t   j_target;

    assign opcode = mips_pkg::opcode_e'(instr_i[31:26]);
    assign funct = mips_pkg::funct_e'(instr_i[5:0]);
    assign rs_addr_o = instr_i[25:21];
    assign rt_addr_o = instr_i[20:16];
    assign slot_pc = pc_i + 32'd4; // Targets are relative to the delay slot
    assign br_target = slot_pc + {{14{instr_i[15]}}, instr_i[15:0], 2'b00};
    assign j_target = {slot_pc[31:28], instr_i[25:0], 2'b00};

    always_comb begin
        ctrl_o = '0;
        ctrl_o.a = rs_val_i;
        ctrl_o.b = rt_val_i;
        ctrl_o.imm = instr_i[15:0];
        ctrl_o.rd = instr_i[20:16];
        branch_taken_o = 1'b0;
        branch_target_o = br_target;
        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                ctrl_o.rd = instr_i[15:11];
                ctrl_o.reg_we = 1'b1;
                case (funct)
                    mips_pkg::FN_ADDU: ctrl_o.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: ctrl_o.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  ctrl_o.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   ctrl_o.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  ctrl_o.alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT:  ctrl_o.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLTU: ctrl_o.alu_op = mips_pkg::ALU_SLTU;
                    mips_pkg::FN_SLL, mips_pkg::FN_SRL: begin
                        ctrl_o.alu_op = mips_pkg::ALU_SLL;
                        if (funct == mips_pkg::FN_SRL) begin
                            ctrl_o.alu_op = mips_pkg::ALU_SRL;
                        end
                        ctrl_o.a = rt_val_i; // Shifts act on rt by shamt
                        ctrl_o.imm = {11'b0, instr_i[10:6]};
                        ctrl_o.imm_sel = 1'b1;
                        ctrl_o.imm_unsigned = 1'b1;
                    end
                    mips_pkg::FN_JR: begin
                        ctrl_o.reg_we = 1'b0;
                        branch_taken_o = 1'b1;
                        branch_target_o = rs_val_i;
                    end
                    default: ctrl_o = '0;
                endcase
            end
            mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_ANDI,
            mips_pkg::OP_ORI, mips_pkg::OP_LUI: begin
                ctrl_o.imm_sel = 1'b1;
                ctrl_o.reg_we = 1'b1;
                case (opcode)
                    mips_pkg::OP_SLTI: ctrl_o.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::OP_ANDI: ctrl_o.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::OP_ORI:  ctrl_o.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::OP_LUI:  ctrl_o.alu_op = mips_pkg::ALU_LUI;
                    default:           ctrl_o.alu_op = mips_pkg::ALU_ADD;
                endcase
                ctrl_o.imm_unsigned = (opcode == mips_pkg::OP_ANDI) || (opcode == mips_pkg::OP_ORI);
            end
            mips_pkg::OP_LW, mips_pkg::OP_LB, mips_pkg::OP_LBU: begin
                ctrl_o.imm_sel = 1'b1;
                ctrl_o.reg_we = 1'b1;
                ctrl_o.mem_op = mips_pkg::MEM_LOAD;
                if (opcode != mips_pkg::OP_LW) begin
                    ctrl_o.mem_size = mips_pkg::SIZE_BYTE;
                end
                ctrl_o.imm_unsigned = (opcode == mips_pkg::OP_LBU);
            end
            mips_pkg::OP_SW, mips_pkg::OP_SB: begin
                ctrl_o.imm_sel = 1'b1;
                ctrl_o.mem_op = mips_pkg::MEM_STORE;
                if (opcode == mips_pkg::OP_SB) begin
                    ctrl_o.mem_size = mips_pkg::SIZE_BYTE;
                end
            end
            mips_pkg::OP_BEQ: branch_taken_o = (rs_val_i == rt_val_i);
            mips_pkg::OP_BNE: branch_taken_o = (rs_val_i != rt_val_i);
            mips_pkg::OP_J: begin
                branch_taken_o = 1'b1;
                branch_target_o = j_target;
            end
            default: ctrl_o = '0; // Unsupported opcode becomes a bubble
        endcase
    end

endmodule

`default_nettype wire

// File: src/operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
    input  wire mips_pkg::reg_addr_t rs_addr_i,
    input  wire mips_pkg::reg_addr_t rt_addr_i,
    input  wire mips_pkg::word_t     rs_file_i,
    input  wire mips_pkg::word_t     rt_file_i,
    input  wire mips_pkg::ex_mm_t    ex_i,
    input  wire mips_pkg::ex_mm_t    mm_i,
    input  wire mips_pkg::word_t     mm_data_i,
    output mips_pkg::word_t          rs_o,
    output mips_pkg::word_t          rt_o,
    output logic                     stall_o
);

    logic ex_is_load;

    function automatic mips_pkg::word_t select_operand(
        input mips_pkg::reg_addr_t addr,
        input mips_pkg::word_t     file_val
    );
        if (addr == '0) begin
            return '0;
        end
        // A load in execute has no data yet, the stall covers that case
        if (ex_i.reg_we && ex_i.rd == addr && ex_i.mem_op != mips_pkg::MEM_LOAD) begin
            return ex_i.result;
        end
        if (mm_i.reg_we && mm_i.rd == addr) begin
            return mm_data_i; // Already holds aligned load data
        end
        return file_val;
    endfunction

    always_comb begin
        rs_o = select_operand(rs_addr_i, rs_file_i);
        rt_o = select_operand(rt_addr_i, rt_file_i);
    end

    assign ex_is_load = (ex_i.mem_op == mips_pkg::MEM_LOAD) && (ex_i.rd != '0);
    assign stall_o = ex_is_load && (ex_i.rd == rs_addr_i || ex_i.rd == rt_addr_i);

endmodule

`default_nettype wire

// File: src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire mips_pkg::mm_wb_t    wb_i,
    input  wire mips_pkg::reg_addr_t rs_addr_i,
    input  wire mips_pkg::reg_addr_t rt_addr_i,
    output mips_pkg::word_t          rs_data_o,
    output mips_pkg::word_t          rt_data_o
);

    mips_pkg::word_t regs [32];
    logic            wr_en;

    assign wr_en = wb_i.we && (wb_i.rd != '0); // Register zero is never stored

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // Write-back in the same cycle wins over the stored value
    assign rs_data_o = (rs_addr_i == '0) ? '0 :
                       (wr_en && wb_i.rd == rs_addr_i) ? wb_i.data : regs[rs_addr_i];
    assign rt_data_o = (rt_addr_i == '0) ? '0 :
                       (wr_en && wb_i.rd == rt_addr_i) ? wb_i.data : regs[rt_addr_i];

endmodule

`default_nettype wire

// File: src/fetch_pc.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_pc #(
    parameter mips_pkg::word_t RESET_PC = '0
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  stall_i,
    input  wire                  branch_taken_i,
    input  wire mips_pkg::word_t branch_target_i,
    output mips_pkg::word_t      pc_o
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_o <= RESET_PC;
        end else if (stall_i) begin
            pc_o <= pc_o; // Refetch while the dependent instruction waits in decode
        end else if (branch_taken_i) begin
            pc_o <= branch_target_i; // Delay slot is already in IF/ID
        end else begin
            pc_o <= pc_o + 32'd4;
        end
    end

endmodule

`default_nettype wire

// File: src/mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE, MEM_LOAD, MEM_STORE
    } mem_op_e;

    typedef enum logic {
        SIZE_WORD, SIZE_BYTE
    } mem_size_e;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00, OP_J = 6'h02, OP_BEQ = 6'h04, OP_BNE = 6'h05,
        OP_ADDIU = 6'h09, OP_SLTI = 6'h0a, OP_ANDI = 6'h0c, OP_ORI = 6'h0d,
        OP_LUI = 6'h0f, OP_LB = 6'h20, OP_LW = 6'h23, OP_LBU = 6'h24,
        OP_SB = 6'h28, OP_SW = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL = 6'h00, FN_SRL = 6'h02, FN_JR = 6'h08, FN_ADDU = 6'h21,
        FN_SUBU = 6'h23, FN_AND = 6'h24, FN_OR = 6'h25, FN_XOR = 6'h26,
        FN_SLT = 6'h2a, FN_SLTU = 6'h2b
    } funct_e;

    typedef struct packed {
        alu_op_e     alu_op;
        word_t       a;
        word_t       b;
        logic [15:0] imm;
        logic        imm_sel;
        logic        imm_unsigned; // Zero-extends ALU immediates and marks LBU on loads
        mem_op_e     mem_op;
        mem_size_e   mem_size;
        reg_addr_t   rd;
        logic        reg_we;
    } id_ex_t;

    typedef struct packed {
        word_t     result; // ALU result or memory address
        word_t     store_data;
        mem_op_e   mem_op;
        mem_size_e mem_size;
        logic      load_unsigned;
        reg_addr_t rd;
        logic      reg_we;
    } ex_mm_t;

    typedef struct packed {
        word_t     data;
        reg_addr_t rd;
        logic      we;
    } mm_wb_t;

    typedef struct packed {
        word_t      addr;
        logic [3:0] be;
        logic       read;
        logic       write;
        word_t      wdata;
    } dbus_req_t;

endpackage

`default_nettype wire
